/* common/packet_params.svh */
// Width, depth and latency constants of the packet read engine, included where a size is needed
`ifndef PACKET_PARAMS_SVH
`define PACKET_PARAMS_SVH

// Memory word and descriptor fields
`define PKT_DATA_BYTES      8
`define PKT_ADDR_WID        10
`define PKT_SIZE_WID        12
`define PKT_META_WID        8

// Read path timing and buffering
`define PKT_MEM_RD_LATENCY  2
`define PKT_INFLIGHT_MAX    4
`define PKT_PREFETCH_DEPTH  4

// Derived widths
// Bytes per word must be a power of two
`define PKT_DATA_WID        (`PKT_DATA_BYTES * 8)
`define PKT_MTY_WID         $clog2(`PKT_DATA_BYTES)
`define PKT_WORD_CNT_WID    (`PKT_SIZE_WID - `PKT_MTY_WID)

`endif

/* common/packet_pkg.sv */
// Shared state, status and record types of the packet read engine, imported by the RTL and the bench
`default_nettype none

`include "packet_params.svh"

package packet_pkg;

    typedef enum logic [1:0] {
        RESET = 2'd0,
        READY = 2'd1,
        BUSY  = 2'd2
    } read_state_e;

    typedef enum logic {
        STATUS_OK  = 1'b0,
        STATUS_ERR = 1'b1
    } pkt_status_e;

    typedef struct packed {
        logic [`PKT_ADDR_WID-1:0] addr;
        logic [`PKT_SIZE_WID-1:0] size;
        logic                     err;
        logic [`PKT_META_WID-1:0] meta;
    } pkt_desc_t;

    // Per-read context, eop and mty only meaningful on the last word
    typedef struct packed {
        logic                     eop;
        logic [`PKT_MTY_WID-1:0]  mty;
        logic                     err;
        logic [`PKT_META_WID-1:0] meta;
    } pkt_ctxt_t;

    // Packet output beat
    typedef struct packed {
        logic [`PKT_DATA_WID-1:0] data;
        logic                     eop;
        logic [`PKT_MTY_WID-1:0]  mty;
        logic                     err;
        logic [`PKT_META_WID-1:0] meta;
    } pkt_word_t;

    // Context fifo entry
    typedef struct packed {
        pkt_ctxt_t                ctxt;
        logic [`PKT_SIZE_WID-1:0] size;
    } pkt_ctxt_rec_t;

    // Prefetch buffer entry
    typedef struct packed {
        pkt_word_t                word;
        logic [`PKT_SIZE_WID-1:0] size;
    } pkt_entry_t;

    typedef struct packed {
        logic                     en;
        logic [`PKT_ADDR_WID-1:0] addr;
        logic [`PKT_DATA_WID-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic                     evt;
        logic [`PKT_SIZE_WID-1:0] size;
        pkt_status_e              status;
    } pkt_event_t;

endpackage

`default_nettype wire

/* packet_read/packet_read_fsm.sv */
// Descriptor-level read controller of the packet read engine, instantiated once in packet_read_top
`timescale 1ns/1ns
`default_nettype none

module packet_read_fsm (
    input  logic                    clk,
    input  logic                    srst,
    input  logic                    desc_valid,
    output logic                    desc_rdy,
    input  logic                    space_ok,
    input  logic                    last,
    output logic                    load,
    output logic                    rd_issue,
    output packet_pkg::read_state_e state
);
    import packet_pkg::*;

    read_state_e nxt_state;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    // --------------------------------------------------
    // Handshake and read issue
    // --------------------------------------------------
    // Counter latches the descriptor when it is first seen in READY
    assign load     = (state == READY) && desc_valid;

    // One read per cycle while the buffer can take every read in flight
    assign rd_issue = (state == BUSY) && space_ok;

    // Descriptor retires with its last read
    assign desc_rdy = rd_issue && last;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                nxt_state = READY;
            end
            READY: begin
                if (desc_valid) begin
                    nxt_state = BUSY;
                end
            end
            BUSY: begin
                if (desc_rdy) begin
                    nxt_state = READY;
                end
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

endmodule

`default_nettype wire

/* packet_read/packet_word_counter.sv */
// Read address and word counter of the packet read engine, loaded per descriptor by the read FSM
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_word_counter (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     load,
    input  packet_pkg::pkt_desc_t    desc,
    input  logic                     rd_issue,
    output logic [`PKT_ADDR_WID-1:0] rd_addr,
    output logic                     last,
    output packet_pkg::pkt_ctxt_t    ctxt_in,
    output logic [`PKT_SIZE_WID-1:0] size_out
);
    localparam int MTY_WID = `PKT_MTY_WID;
    localparam int CNT_WID = `PKT_WORD_CNT_WID;

    logic [CNT_WID-1:0]       word_cnt;
    logic [CNT_WID-1:0]       last_word;
    logic [MTY_WID-1:0]       last_mty;
    logic                     err_q;
    logic [`PKT_META_WID-1:0] meta_q;
    logic [`PKT_SIZE_WID-1:0] size_m1;
    logic [MTY_WID-1:0]       size_lo;

    // Last word index is (size - 1) / bytes per word
    assign size_m1 = desc.size - 1'b1;
    assign size_lo = desc.size[MTY_WID-1:0];

    // --------------------------------------------------
    // Address and word count
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_addr   <= '0;
            word_cnt  <= '0;
            last_word <= '0;
        end else if (load) begin
            rd_addr   <= desc.addr;
            word_cnt  <= '0;
            last_word <= size_m1[`PKT_SIZE_WID-1:MTY_WID];
        end else if (rd_issue) begin
            rd_addr  <= rd_addr + 1'b1;
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // Packet attributes held for the whole descriptor
    always_ff @(posedge clk) begin
        if (load) begin
            // Negated low size bits give (W - size mod W) mod W
            last_mty <= '0 - size_lo;
            err_q    <= desc.err;
            meta_q   <= desc.meta;
            size_out <= desc.size;
        end
    end

    assign last = (word_cnt == last_word);

    // Context of the read issued this cycle
    always_comb begin
        ctxt_in.eop  = last;
        ctxt_in.mty  = last ? last_mty : '0;
        ctxt_in.err  = err_q;
        ctxt_in.meta = meta_q;
    end

endmodule

`default_nettype wire

/* packet_read/packet_ctxt_fifo.sv */
// In-order context queue pairing each memory read with its context, from issue to acknowledge
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_ctxt_fifo (
    input  logic                      clk,
    input  logic                      srst,
    input  logic                      wr,
    input  packet_pkg::pkt_ctxt_rec_t wr_data,
    input  logic                      rd,
    output packet_pkg::pkt_ctxt_rec_t rd_data,
    output logic                      oflow,
    output logic                      uflow
);
    import packet_pkg::*;

    // Depth must be a power of two so the pointers wrap on their own
    localparam int DEPTH   = `PKT_INFLIGHT_MAX;
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    pkt_ctxt_rec_t      entries [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);
    assign push  = wr && (!full || rd);
    assign pop   = rd && !empty;

    // Error flags for the bound checks
    assign oflow = wr && !push;
    assign uflow = rd && empty;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = entries[rd_ptr];

endmodule

`default_nettype wire

/* packet_read/packet_prefetch_buf.sv */
// Prefetch buffer that holds returned words, gates read issue by free space and drives the packet output
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_prefetch_buf (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   rd_issue,
    input  logic                   wr,
    input  packet_pkg::pkt_entry_t wr_data,
    output logic                   space_ok,
    output logic                   pkt_valid,
    output packet_pkg::pkt_word_t  pkt,
    input  logic                   pkt_rdy,
    output packet_pkg::pkt_event_t event_out
);
    import packet_pkg::*;

    localparam int DEPTH   = `PKT_PREFETCH_DEPTH;
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    pkt_entry_t         entries [DEPTH];
    pkt_entry_t         head;
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] inflight;
    logic [CNT_WID-1:0] free_cnt;
    logic               pop;

    // --------------------------------------------------
    // Space accounting
    // --------------------------------------------------
    // Reads in flight each hold a reserved entry
    always_ff @(posedge clk) begin
        if (srst) begin
            inflight <= '0;
        end else if (rd_issue && !wr) begin
            inflight <= inflight + 1'b1;
        end else if (wr && !rd_issue) begin
            inflight <= inflight - 1'b1;
        end
    end

    assign free_cnt = CNT_WID'(DEPTH) - count;
    assign space_ok = (free_cnt > inflight);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    assign pop = pkt_valid && pkt_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            entries[wr_ptr] <= wr_data;
        end
    end

    // --------------------------------------------------
    // Output beat and completion event
    // --------------------------------------------------
    assign head      = entries[rd_ptr];
    assign pkt_valid = (count != '0);
    assign pkt       = head.word;

    assign event_out.evt    = pop && head.word.eop;
    assign event_out.size   = head.size;
    assign event_out.status = head.word.err ? STATUS_ERR : STATUS_OK;

endmodule

`default_nettype wire

/* verilog/packet_mem.sv */
// On-chip packet memory with a load write port and a fixed-latency read port used by the read engine
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_mem (
    input  logic                     clk,
    input  packet_pkg::mem_wr_t      mem_wr,
    input  logic                     rd_en,
    input  logic [`PKT_ADDR_WID-1:0] rd_addr,
    output logic                     rd_ack,
    output logic [`PKT_DATA_WID-1:0] rd_data
);
    localparam int LATENCY = `PKT_MEM_RD_LATENCY;
    localparam int WORDS   = 2 ** `PKT_ADDR_WID;

    logic [`PKT_DATA_WID-1:0] mem_array [WORDS];
    logic [`PKT_DATA_WID-1:0] data_pipe [LATENCY];
    logic [LATENCY-1:0]       vld_pipe;

    // Load port
    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem_array[mem_wr.addr] <= mem_wr.data;
        end
    end

    // --------------------------------------------------
    // Registered read path
    // --------------------------------------------------
    // Array read in the first stage, then output register stages
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_pipe[0] <= mem_array[rd_addr];
        end
        vld_pipe[0] <= rd_en;
        for (int i = 1; i < LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
            vld_pipe[i]  <= vld_pipe[i-1];
        end
    end

    assign rd_ack  = vld_pipe[LATENCY-1];
    assign rd_data = data_pipe[LATENCY-1];

endmodule

`default_nettype wire

/* verilog/packet_read_top.sv */
// Top level of the packet read subsystem, joining the read engine to the packet memory
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_read_top (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   desc_valid,
    input  packet_pkg::pkt_desc_t  desc,
    output logic                   desc_rdy,
    input  packet_pkg::mem_wr_t    mem_wr,
    output logic                   pkt_valid,
    output packet_pkg::pkt_word_t  pkt,
    input  logic                   pkt_rdy,
    output packet_pkg::pkt_event_t event_out
);
    import packet_pkg::*;

    // Read control
    read_state_e              fsm_state;
    logic                     load;
    logic                     rd_issue;
    logic                     last;
    logic                     space_ok;
    logic [`PKT_ADDR_WID-1:0] rd_addr;

    // Context path
    pkt_ctxt_t                ctxt_in;
    logic [`PKT_SIZE_WID-1:0] size_out;
    pkt_ctxt_rec_t            ctxt_wr;
    pkt_ctxt_rec_t            ctxt_rd;
    logic                     ctxt_oflow;
    logic                     ctxt_uflow;

    // Memory return
    logic                     rd_ack;
    logic [`PKT_DATA_WID-1:0] rd_data;
    pkt_entry_t               buf_wr;

    assign ctxt_wr = '{ctxt: ctxt_in, size: size_out};

    // Returned word joined with the context popped at the same acknowledge
    assign buf_wr.word.data = rd_data;
    assign buf_wr.word.eop  = ctxt_rd.ctxt.eop;
    assign buf_wr.word.mty  = ctxt_rd.ctxt.mty;
    assign buf_wr.word.err  = ctxt_rd.ctxt.err;
    assign buf_wr.word.meta = ctxt_rd.ctxt.meta;
    assign buf_wr.size      = ctxt_rd.size;

    // --------------------------------------------------
    // Read engine
    // --------------------------------------------------
    packet_read_fsm i_packet_read_fsm (
        .clk        (clk),
        .srst       (srst),
        .desc_valid (desc_valid),
        .desc_rdy   (desc_rdy),
        .space_ok   (space_ok),
        .last       (last),
        .load       (load),
        .rd_issue   (rd_issue),
        .state      (fsm_state)
    );

    packet_word_counter i_packet_word_counter (
        .clk      (clk),
        .srst     (srst),
        .load     (load),
        .desc     (desc),
        .rd_issue (rd_issue),
        .rd_addr  (rd_addr),
        .last     (last),
        .ctxt_in  (ctxt_in),
        .size_out (size_out)
    );

    packet_ctxt_fifo i_packet_ctxt_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (rd_issue),
        .wr_data (ctxt_wr),
        .rd      (rd_ack),
        .rd_data (ctxt_rd),
        .oflow   (ctxt_oflow),
        .uflow   (ctxt_uflow)
    );

    packet_prefetch_buf i_packet_prefetch_buf (
        .clk       (clk),
        .srst      (srst),
        .rd_issue  (rd_issue),
        .wr        (rd_ack),
        .wr_data   (buf_wr),
        .space_ok  (space_ok),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .pkt_rdy   (pkt_rdy),
        .event_out (event_out)
    );

    // --------------------------------------------------
    // Packet memory
    // --------------------------------------------------
    packet_mem i_packet_mem (
        .clk     (clk),
        .mem_wr  (mem_wr),
        .rd_en   (rd_issue),
        .rd_addr (rd_addr),
        .rd_ack  (rd_ack),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* bench/packet_read_props.sv */
// Concurrent protocol checks on the packet read top level, bound into packet_read_top
`timescale 1ns/1ns
`default_nettype none

module packet_read_props (
    input logic                    clk,
    input logic                    srst,
    input logic                    desc_rdy,
    input logic                    pkt_valid,
    input packet_pkg::pkt_word_t   pkt,
    input logic                    pkt_rdy,
    input packet_pkg::pkt_event_t  event_out,
    input packet_pkg::read_state_e state,
    input logic                    oflow,
    input logic                    uflow
);
    import packet_pkg::*;

    // Count of failed checks
    int fail_cnt = 0;

    // --------------------------------------------------
    // Output handshake
    // --------------------------------------------------
    a_pkt_hold: assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && !pkt_rdy) |=> (pkt_valid && $stable(pkt)))
    else begin
        fail_cnt++;
        $error("pkt dropped or changed while stalled");
    end

    a_evt_eop: assert property (@(posedge clk) disable iff (srst)
        event_out.evt |-> (pkt_valid && pkt_rdy && pkt.eop))
    else begin
        fail_cnt++;
        $error("completion event without a transferring eop beat");
    end

    // --------------------------------------------------
    // Internal state
    // --------------------------------------------------
    a_rdy_busy: assert property (@(posedge clk) disable iff (srst)
        desc_rdy |-> (state == BUSY))
    else begin
        fail_cnt++;
        $error("desc_rdy high outside BUSY");
    end

    a_ctxt_oflow: assert property (@(posedge clk) disable iff (srst) !oflow)
    else begin
        fail_cnt++;
        $error("context fifo overflow");
    end

    a_ctxt_uflow: assert property (@(posedge clk) disable iff (srst) !uflow)
    else begin
        fail_cnt++;
        $error("context fifo underflow");
    end

endmodule

bind packet_read_top packet_read_props i_packet_read_props (
    .clk       (clk),
    .srst      (srst),
    .desc_rdy  (desc_rdy),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .pkt_rdy   (pkt_rdy),
    .event_out (event_out),
    .state     (fsm_state),
    .oflow     (ctxt_oflow),
    .uflow     (ctxt_uflow)
);

`default_nettype wire

/* bench/packet_read_tb.sv */
// Self-checking testbench for the packet read subsystem, run as the simulation top with the bound checks
`timescale 1ns/1ns
`default_nettype none

`include "packet_params.svh"

module packet_read_tb;
    import packet_pkg::*;

    localparam int WORD_BYTES = `PKT_DATA_BYTES;
    localparam int MTY_WID    = `PKT_MTY_WID;
    localparam int WAIT_LIMIT = 2000;

    logic       clk;
    logic       srst;
    logic       desc_valid;
    pkt_desc_t  desc;
    logic       desc_rdy;
    mem_wr_t    mem_wr;
    logic       pkt_valid;
    pkt_word_t  pkt;
    logic       pkt_rdy;
    pkt_event_t event_out;

    // Mirror of the loaded memory and the expected beat stream
    logic [`PKT_DATA_WID-1:0] image [2 ** `PKT_ADDR_WID];
    pkt_entry_t               exp_q [$];

    logic [31:0] data_state;
    logic [31:0] rdy_state;
    logic        rdy_random;
    logic        lat_armed;
    int          next_addr;
    int          cyc;
    int          start_cyc;
    int          rdy_pulses;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;
    string       test_name;

    packet_read_top i_packet_read_top (
        .clk        (clk),
        .srst       (srst),
        .desc_valid (desc_valid),
        .desc       (desc),
        .desc_rdy   (desc_rdy),
        .mem_wr     (mem_wr),
        .pkt_valid  (pkt_valid),
        .pkt        (pkt),
        .pkt_rdy    (pkt_rdy),
        .event_out  (event_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        data_state = lcg_next(data_state);
        return data_state;
    endfunction

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
            tests_failed++;
        end
    endtask

    // Writes random words for one packet and returns its descriptor
    task automatic load_packet(input int size, input logic err,
                               input logic [`PKT_META_WID-1:0] meta, output pkt_desc_t d);
        int nwords;
        nwords = (size + WORD_BYTES - 1) / WORD_BYTES;
        d.addr = next_addr[`PKT_ADDR_WID-1:0];
        d.size = size[`PKT_SIZE_WID-1:0];
        d.err  = err;
        d.meta = meta;
        for (int i = 0; i < nwords; i++) begin
            @(negedge clk);
            mem_wr.en   = 1'b1;
            mem_wr.addr = next_addr[`PKT_ADDR_WID-1:0];
            mem_wr.data = {rand32(), rand32()};
            image[next_addr] = mem_wr.data;
            next_addr++;
        end
        @(negedge clk);
        mem_wr.en = 1'b0;
    endtask

    // Queues the expected beats, then holds the descriptor until accepted
    task automatic send_packet(input pkt_desc_t d);
        int         nwords;
        int         n;
        pkt_entry_t e;
        nwords = (int'(d.size) + WORD_BYTES - 1) / WORD_BYTES;
        for (int i = 0; i < nwords; i++) begin
            e.word.data = image[d.addr + i];
            e.word.eop  = (i == nwords - 1);
            e.word.mty  = '0;
            if (e.word.eop) begin
                e.word.mty = MTY_WID'((WORD_BYTES - int'(d.size) % WORD_BYTES) % WORD_BYTES);
            end
            e.word.err  = d.err;
            e.word.meta = d.meta;
            e.size      = d.size;
            exp_q.push_back(e);
        end
        desc       = d;
        desc_valid = 1'b1;
        n = 0;
        while (desc_rdy !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (desc_rdy !== 1'b1) begin
            $display("Timeout: descriptor at address %0d not accepted in test %s", d.addr,
                     test_name);
            errors++;
        end
        @(negedge clk);
        desc_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d beats never came out in test %s", exp_q.size(), test_name);
            errors++;
            exp_q.delete();
        end
        lat_armed = 1'b0;
    endtask

    task automatic check_idle();
        check_eq("desc_rdy", 64'd0, 64'(desc_rdy));
        check_eq("pkt_valid", 64'd0, 64'(pkt_valid));
        check_eq("event_out.evt", 64'd0, 64'(event_out.evt));
    endtask

    // Switched at a rising edge so the falling-edge driver sees a settled mode
    task automatic set_backpressure(input logic on);
        @(posedge clk);
        rdy_random = on;
        @(negedge clk);
    endtask

    // --------------------------------------------------
    // Output driver and scoreboard
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rdy_random) begin
            rdy_state = lcg_next(rdy_state);
            pkt_rdy   = rdy_state[30];
        end else begin
            pkt_rdy = 1'b1;
        end
    end

    always @(posedge clk) begin
        pkt_entry_t e;
        if (desc_rdy === 1'b1) begin
            rdy_pulses++;
        end
        if (pkt_valid === 1'b1 && pkt_rdy === 1'b1) begin
            if (lat_armed) begin
                check_eq("first beat latency", 64'd4, 64'(cyc - start_cyc));
                lat_armed = 1'b0;
            end
            assert (exp_q.size() != 0) else begin
                $display("Unexpected beat with no beat left to expect in test %s", test_name);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_eq("data", e.word.data, pkt.data);
                check_eq("eop", 64'(e.word.eop), 64'(pkt.eop));
                check_eq("mty", 64'(e.word.mty), 64'(pkt.mty));
                check_eq("err", 64'(e.word.err), 64'(pkt.err));
                check_eq("meta", 64'(e.word.meta), 64'(pkt.meta));
                check_eq("event_out.evt", 64'(e.word.eop), 64'(event_out.evt));
                if (e.word.eop) begin
                    check_eq("event_out.size", 64'(e.size), 64'(event_out.size));
                    check_eq("event_out.status", 64'(e.word.err ? STATUS_ERR : STATUS_OK),
                             64'(event_out.status));
                end
            end
        end
        cyc++;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        pkt_desc_t d;
        pkt_desc_t batch [20];
        int        size;
        int        rdy_before;
        int        prop_fails;
        srst       = 1'b1;
        desc_valid = 1'b0;
        desc       = '0;
        mem_wr     = '0;
        pkt_rdy    = 1'b1;
        rdy_random = 1'b0;
        lat_armed  = 1'b0;
        data_state = 32'd85990;
        rdy_state  = 32'd85990;
        next_addr  = 0;
        cyc        = 0;
        start_cyc  = 0;
        rdy_pulses = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        test_name  = "setup";

        begin_test("reset");
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_idle();
        end
        srst = 1'b0;
        @(negedge clk);
        check_idle();
        end_test();

        begin_test("data path");
        load_packet(64, 1'b0, 8'h5a, d);
        start_cyc = cyc;
        lat_armed = 1'b1;
        send_packet(d);
        wait_drain();
        end_test();

        begin_test("last word framing");
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: size = 1;
                1: size = 8;
                2: size = 9;
                default: size = int'((rand32() >> 8) % 40) + 1;
            endcase
            load_packet(size, 1'b0, 8'(rand32() >> 16), d);
            send_packet(d);
        end
        wait_drain();
        end_test();

        begin_test("metadata and error");
        for (int i = 0; i < 6; i++) begin
            size = int'((rand32() >> 8) % 40) + 1;
            load_packet(size, i[0], 8'(rand32() >> 16), d);
            send_packet(d);
        end
        wait_drain();
        end_test();

        begin_test("back-pressure");
        for (int i = 0; i < 20; i++) begin
            size = int'((rand32() >> 8) % 40) + 1;
            load_packet(size, 1'(rand32() >> 31), 8'(rand32() >> 16), batch[i]);
        end
        rdy_before = rdy_pulses;
        set_backpressure(1'b1);
        for (int i = 0; i < 20; i++) begin
            send_packet(batch[i]);
        end
        wait_drain();
        set_backpressure(1'b0);
        check_eq("desc_rdy pulses", 64'd20, 64'(rdy_pulses - rdy_before));
        end_test();

        prop_fails = i_packet_read_top.i_packet_read_props.fail_cnt;
        $display("tests run %0d, tests failed %0d, check errors %0d, property failures %0d",
                 tests_run, tests_failed, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/packet_pkg.sv
packet_read/packet_read_fsm.sv
packet_read/packet_word_counter.sv
packet_read/packet_ctxt_fifo.sv
packet_read/packet_prefetch_buf.sv
verilog/packet_mem.sv
verilog/packet_read_top.sv
bench/packet_read_props.sv
bench/packet_read_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the packet read testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module packet_read_tb \
    -f filelist.f -Mdir obj_dir -o packet_read_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/packet_read_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1
